/* list.f */
source/rv_pkg.sv
source/rv_if.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_control.sv
source/rv_core.sv
sim/tb_clock.sv
sim/tb_top.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module tb_top -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_top); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

/* sim/tb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_top;
  import rv_pkg::*;

  logic clk;
  logic rstn = 1'b0;
  logic [31:0] araddr, awaddr, wdata;
  logic [31:0] rdata = '0;
  logic [3:0] wstrb;
  logic arvalid, rready, awvalid, wvalid, bready;
  logic arready = 1'b0;
  logic rvalid = 1'b0;
  logic awready = 1'b0;
  logic wready = 1'b0;
  logic bvalid = 1'b0;
  logic ar_hs, r_hs, aw_hs, w_hs, b_hs;

  logic [31:0] mem [0:255];
  logic [31:0] img [0:255];
  logic [31:0] img_pc, halt_addr, rd_addr, seed;
  logic [11:0] out_off;
  logic [1:0] ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
  logic r_wait = 1'b0;
  logic b_wait = 1'b0;
  logic aw_done = 1'b0;
  logic w_done = 1'b0;
  logic halted = 1'b0;
  logic fetched = 1'b0;
  logic rst_chk = 1'b0;
  logic [67:0] exp_q [$];
  string name_q [$];
  logic [67:0] exp_head = '0;
  string exp_name = "";
  logic exp_ok = 1'b0;

  tb_clock u_clock (.clk(clk));

  rv_core dut (
    .clk(clk), .rstn(rstn), .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rvalid(rvalid), .rready(rready), .awaddr(awaddr), .awvalid(awvalid),
    .awready(awready), .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bvalid(bvalid), .bready(bready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [1:0] rand_delay();
    seed = lcg_next(seed);
    return seed[17:16];
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {f7, rs2, rs1, f3, 5'd3, op_reg}; // result always in x3
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  task automatic put(input logic [31:0] w);
    img[img_pc[9:2]] = w;
    img_pc = img_pc + 32'd4;
  endtask

  task automatic push_exp(input string name, input logic [31:0] addr,
                          input logic [31:0] data, input logic [3:0] strb);
    exp_q.push_back({addr, data, strb});
    name_q.push_back(name);
  endtask

  // sw src into the next word of the result area at 0x300
  task automatic store_result(input string name, input logic [4:0] src, input logic [31:0] v);
    put(enc_s(out_off, src, 5'd5, f3_sw));
    push_exp(name, 32'h300 + {20'd0, out_off}, v, 4'hf);
    out_off = out_off + 12'd4;
  endtask

  task automatic run_op(input string name, input logic [31:0] w, input logic [31:0] v);
    put(w);
    store_result(name, 5'd3, v);
  endtask

  // taken branch skips a poison store, the not-taken one falls into a real store
  task automatic branch_pair(input string name, input logic [2:0] f3, input logic [4:0] t1,
                             input logic [4:0] t2, input logic [4:0] n1, input logic [4:0] n2);
    put(enc_b(13'd8, t2, t1, f3));
    put(enc_s(12'd0, 5'd2, 5'd7, f3_sw));
    put(enc_b(13'd8, n2, n1, f3));
    store_result({name, " not taken"}, 5'd1, 32'h12345678);
  endtask

  always @(posedge clk) begin
    ar_hs <= arvalid && arready;
    r_hs <= rvalid && rready;
    aw_hs <= awvalid && awready;
    w_hs <= wvalid && wready;
    b_hs <= bvalid && bready;
  end

  // memory model driving on the falling edge
  always @(negedge clk) begin
    if (!rstn) begin
      mem = img;
      {arready, rvalid, awready, wready, bvalid} = '0;
      ar_cnt = rand_delay();
      aw_cnt = rand_delay();
      w_cnt = rand_delay();
    end else begin
      if (ar_hs) begin
        arready = 1'b0;
        rd_addr = araddr;
        fetched = 1'b1;
        r_wait = 1'b1;
        r_cnt = rand_delay();
        ar_cnt = rand_delay();
      end else if (arvalid && !arready) begin
        if (ar_cnt == 0) arready = 1'b1;
        else ar_cnt = ar_cnt - 2'd1;
      end
      if (r_hs) begin
        rvalid = 1'b0;
        if (rd_addr == halt_addr) halted = 1'b1;
      end else if (r_wait) begin
        if (r_cnt == 0) begin
          rvalid = 1'b1;
          rdata = mem[rd_addr[9:2]];
          r_wait = 1'b0;
        end else r_cnt = r_cnt - 2'd1;
      end
      if (aw_hs) begin
        awready = 1'b0;
        aw_done = 1'b1;
        aw_cnt = rand_delay();
      end else if (awvalid && !awready) begin
        if (aw_cnt == 0) awready = 1'b1;
        else aw_cnt = aw_cnt - 2'd1;
      end
      if (w_hs) begin
        wready = 1'b0;
        w_done = 1'b1;
        w_cnt = rand_delay();
        for (int b = 0; b < 4; b++)
          if (wstrb[b]) mem[awaddr[9:2]][8*b +: 8] = wdata[8*b +: 8];
        void'(exp_q.pop_front());
        void'(name_q.pop_front());
      end else if (wvalid && !wready) begin
        if (w_cnt == 0) wready = 1'b1;
        else w_cnt = w_cnt - 2'd1;
      end
      if (b_hs) begin
        bvalid = 1'b0;
      end else if (b_wait) begin
        if (b_cnt == 0) begin
          bvalid = 1'b1;
          b_wait = 1'b0;
        end else b_cnt = b_cnt - 2'd1;
      end else if (aw_done && w_done && !bvalid) begin
        b_wait = 1'b1;
        b_cnt = rand_delay();
        aw_done = 1'b0;
        w_done = 1'b0;
      end
    end
    exp_ok = exp_q.size() != 0;
    if (exp_ok) begin
      exp_head = exp_q[0];
      exp_name = name_q[0];
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    rst_chk |-> !(arvalid || awvalid || wvalid || rready || bready)) else begin
    $display("TEST FAIL");
    $display("bus valid or ready high during reset");
    $fatal(1);
  end

  a_first_fetch: assert property (@(posedge clk) disable iff (!rstn)
    (arvalid && !fetched) |-> araddr == reset_pc) else begin
    $display("TEST FAIL");
    $display("mismatch first fetch expected %h actual %h", reset_pc, araddr);
    $fatal(1);
  end

  a_store_expected: assert property (@(posedge clk) disable iff (!rstn)
    (wvalid && wready) |-> exp_ok) else begin
    $display("TEST FAIL");
    $display("store to %h that no instruction should make", awaddr);
    $fatal(1);
  end

  a_store_value: assert property (@(posedge clk) disable iff (!rstn)
    (wvalid && wready && exp_ok) |-> {awaddr, wdata, wstrb} == exp_head) else begin
    $display("TEST FAIL");
    $display("mismatch %s expected %h actual %h", exp_name, exp_head, {awaddr, wdata, wstrb});
    $fatal(1);
  end

  a_halt_quiet: assert property (@(posedge clk) halted |-> !(arvalid || awvalid)) else begin
    $display("TEST FAIL");
    $display("bus request after the core halted");
    $fatal(1);
  end

  initial begin
    logic [31:0] p;
    logic [31:0] ld_word;
    logic [7:0] bv;
    logic [15:0] hv;
    int cycles;
    seed = 32'hfefb1989;
    img_pc = reset_pc;
    out_off = 12'd0;
    ld_word = 32'h8091a2f3;
    for (int i = 0; i < 256; i++) img[i] = 32'ha5000000 ^ (i * 32'h01030507);
    img[128] = ld_word; // load data at 0x200
    put({20'h12345, 5'd1, op_lui});
    put(enc_i(12'h678, 5'd1, f3_add, 5'd1, op_imm));
    put(enc_i(12'hffb, 5'd0, f3_add, 5'd2, op_imm)); // x2 = -5
    put(enc_i(12'h300, 5'd0, f3_add, 5'd5, op_imm));
    put(enc_i(12'h200, 5'd0, f3_add, 5'd6, op_imm));
    put(enc_i(12'h280, 5'd0, f3_add, 5'd7, op_imm));
    store_result("lui addi", 5'd1, 32'h12345678);
    run_op("add", enc_r(f7_base, 5'd2, 5'd1, f3_add), 32'h12345673);
    run_op("sub", enc_r(f7_alt, 5'd2, 5'd1, f3_add), 32'h1234567d);
    run_op("xor", enc_r(f7_base, 5'd2, 5'd1, f3_xor), 32'hedcba983);
    run_op("or", enc_r(f7_base, 5'd2, 5'd1, f3_or), 32'hfffffffb);
    run_op("andi", enc_i(12'h0f0, 5'd1, f3_and, 5'd3, op_imm), 32'h00000070);
    run_op("slli", enc_i(12'd4, 5'd1, f3_sll, 5'd3, op_imm), 32'h23456780);
    run_op("srli", enc_i(12'd4, 5'd2, f3_srl, 5'd3, op_imm), 32'h0fffffff);
    run_op("srai", enc_i({f7_alt, 5'd1}, 5'd2, f3_srl, 5'd3, op_imm), 32'hfffffffd);
    run_op("slt", enc_r(f7_base, 5'd1, 5'd2, f3_slt), 32'd1);
    run_op("sltu", enc_r(f7_base, 5'd1, 5'd2, f3_sltu), 32'd0);
    run_op("auipc", {20'h00001, 5'd3, op_auipc}, img_pc + 32'h1000);
    for (int k = 0; k < 4; k++) begin
      bv = 8'(ld_word >> (8 * (3 - k))); // offset 0 is the top byte
      run_op($sformatf("lb %0d", k), enc_i(12'(k), 5'd6, f3_lb, 5'd3, op_load),
             {{24{bv[7]}}, bv});
      run_op($sformatf("lbu %0d", k), enc_i(12'(k), 5'd6, f3_lbu, 5'd3, op_load),
             {24'd0, bv});
    end
    for (int k = 0; k < 4; k += 2) begin
      hv = 16'(ld_word >> (8 * (2 - k)));
      run_op($sformatf("lh %0d", k), enc_i(12'(k), 5'd6, f3_lh, 5'd3, op_load),
             {{16{hv[15]}}, hv});
      run_op($sformatf("lhu %0d", k), enc_i(12'(k), 5'd6, f3_lhu, 5'd3, op_load),
             {16'd0, hv});
    end
    run_op("lw", enc_i(12'd0, 5'd6, f3_lw, 5'd3, op_load), ld_word);
    for (int k = 0; k < 4; k++) begin
      put(enc_s(12'(k), 5'd1, 5'd7, f3_sb));
      push_exp($sformatf("sb %0d", k), 32'h280, 32'h78 << (8 * (3 - k)), 4'b0001 << (3 - k));
    end
    for (int k = 0; k < 4; k += 2) begin
      put(enc_s(12'(k), 5'd1, 5'd7, f3_sh));
      push_exp($sformatf("sh %0d", k), 32'h280, 32'h5678 << (8 * (2 - k)), 4'b0011 << (2 - k));
    end
    branch_pair("beq", f3_beq, 5'd1, 5'd1, 5'd1, 5'd2);
    branch_pair("bne", f3_bne, 5'd1, 5'd2, 5'd1, 5'd1);
    branch_pair("blt", f3_blt, 5'd2, 5'd1, 5'd1, 5'd2);
    branch_pair("bge", f3_bge, 5'd1, 5'd2, 5'd2, 5'd1);
    branch_pair("bltu", f3_bltu, 5'd1, 5'd2, 5'd2, 5'd1);
    branch_pair("bgeu", f3_bgeu, 5'd2, 5'd1, 5'd1, 5'd2);
    p = img_pc;
    put({1'b0, 10'd4, 1'b0, 8'd0, 5'd4, op_jal}); // jal x4, +8
    put(enc_s(12'd0, 5'd2, 5'd7, f3_sw));
    store_result("jal link", 5'd4, p + 32'd4);
    p = img_pc;
    put(enc_i(12'(p + 32'd13), 5'd0, f3_add, 5'd8, op_imm)); // odd target whose bit 0 is dropped
    put(enc_i(12'd0, 5'd8, 3'b000, 5'd4, op_jalr));
    put(enc_s(12'd0, 5'd2, 5'd7, f3_sw));
    store_result("jalr link", 5'd4, p + 32'd8);
    halt_addr = img_pc;
    put(32'h0000_0000);

    @(negedge clk);
    rst_chk = 1'b1;
    repeat (9) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    rst_chk = 1'b0;
    cycles = 0;
    while (!halted) begin
      @(negedge clk);
      cycles++;
      if (cycles > 50000) begin
        $display("TEST FAIL");
        $display("timeout while waiting for the fetch of the invalid word");
        $fatal(1);
      end
    end
    repeat (200) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("TEST FAIL");
      $display("%0d expected stores never appeared, next is %s", exp_q.size(), name_q[0]);
      $fatal(1);
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk
);

  initial clk = 1'b0;

  always #20 clk = ~clk; // 40 ns period

endmodule

`default_nettype wire

/* source/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core (
  input logic clk,
  input logic rstn,
  output logic [rv_pkg::xlen-1:0] araddr,
  output logic arvalid,
  input logic arready,
  input logic [rv_pkg::xlen-1:0] rdata,
  input logic rvalid,
  output logic rready,
  output logic [rv_pkg::xlen-1:0] awaddr,
  output logic awvalid,
  input logic awready,
  output logic [rv_pkg::xlen-1:0] wdata,
  output logic [rv_pkg::strb_w-1:0] wstrb,
  output logic wvalid,
  input logic wready,
  input logic bvalid,
  output logic bready
);
  import rv_pkg::*;

  logic [xlen-1:0] instr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] alu_result;
  logic rf_we;
  logic [xlen-1:0] rf_wdata;

  dec_if dec_bus ();
  mem_if mem_bus ();

  rv_decoder u_decoder (.clk(clk), .rstn(rstn), .instr(instr), .dec(dec_bus.producer));

  rv_regfile u_regfile (
    .clk(clk), .rstn(rstn), .we(rf_we), .rd(dec_bus.rd), .wdata(rf_wdata),
    .rs1(dec_bus.rs1), .rs2(dec_bus.rs2), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv_alu u_alu (
    .clk(clk), .rstn(rstn), .dec(dec_bus.consumer),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .result(alu_result)
  );

  rv_control u_control (
    .clk(clk), .rstn(rstn), .dec(dec_bus.consumer), .instr(instr),
    .alu_result(alu_result), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rf_we(rf_we), .rf_wdata(rf_wdata), .mem(mem_bus.master)
  );

  rv_lsu u_lsu (
    .clk(clk), .rstn(rstn), .mem(mem_bus.slave),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rvalid(rvalid), .rready(rready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bvalid(bvalid), .bready(bready)
  );

endmodule

`default_nettype wire

/* source/rv_control.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_control (
  input logic clk,
  input logic rstn,
  dec_if.consumer dec,
  output logic [rv_pkg::xlen-1:0] instr,
  input logic [rv_pkg::xlen-1:0] alu_result,
  input logic [rv_pkg::xlen-1:0] rs1_data,
  input logic [rv_pkg::xlen-1:0] rs2_data,
  output logic rf_we,
  output logic [rv_pkg::xlen-1:0] rf_wdata,
  mem_if.master mem
);
  import rv_pkg::*;

  core_state_t state;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] load_val;
  logic [xlen-1:0] ls_addr;
  logic [xlen-1:0] next_pc;
  logic is_load;
  logic is_store;

  assign is_load = dec.op inside {lb, lh, lw, lbu, lhu};
  assign is_store = dec.op inside {sb, sh, sw};
  assign ls_addr = rs1_data + dec.imm; // also the jalr target

  assign mem.req = (state == st_fetch) || (state == st_mem && (is_load || is_store));
  assign mem.kind = (state == st_fetch) ? mk_fetch : (is_store ? mk_store : mk_load);
  assign mem.addr = (state == st_fetch) ? pc : ls_addr;
  assign mem.is_unsigned = dec.op inside {lbu, lhu};
  assign mem.wdata = rs2_data;

  always_comb begin
    case (dec.op)
      lb, lbu, sb: mem.size = sz_byte;
      lh, lhu, sh: mem.size = sz_half;
      default: mem.size = sz_word;
    endcase
  end

  always_comb begin
    case (dec.op)
      lui: rf_wdata = dec.imm;
      auipc: rf_wdata = pc + dec.imm;
      jal, jalr: rf_wdata = pc + 32'd4; // link
      lb, lh, lw, lbu, lhu: rf_wdata = load_val;
      default: rf_wdata = alu_result;
    endcase
  end

  always_comb begin
    case (dec.op)
      jal: next_pc = pc + dec.imm;
      jalr: next_pc = {ls_addr[xlen-1:1], 1'b0};
      beq, bne, blt, bge, bltu, bgeu:
        next_pc = (alu_result != '0) ? pc + dec.imm : pc + 32'd4;
      default: next_pc = pc + 32'd4;
    endcase
  end

  assign rf_we = (state == st_write) && (dec.rd != '0);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= st_fetch;
      pc <= reset_pc;
      instr <= '0;
    end else begin
      case (state)
        st_fetch: begin
          if (mem.done) begin
            instr <= mem.rdata;
            state <= st_decode;
          end
        end
        st_decode: state <= st_exec;
        st_exec: state <= (dec.op == inst_inval) ? st_halt : st_mem;
        st_mem: if (!(is_load || is_store) || mem.done) state <= st_write;
        st_write: begin
          pc <= next_pc;
          state <= st_fetch;
        end
        default: state <= st_halt; // stays here for good
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_mem && mem.done) load_val <= mem.rdata;
  end

  a_req_held: assert property (@(posedge clk) disable iff (!rstn)
    mem.req && !mem.done |=> mem.req && $stable(mem.addr));

endmodule

`default_nettype wire

/* source/rv_lsu.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_lsu (
  input logic clk,
  input logic rstn,
  mem_if.slave mem,
  output logic [rv_pkg::xlen-1:0] araddr,
  output logic arvalid,
  input logic arready,
  input logic [rv_pkg::xlen-1:0] rdata,
  input logic rvalid,
  output logic rready,
  output logic [rv_pkg::xlen-1:0] awaddr,
  output logic awvalid,
  input logic awready,
  output logic [rv_pkg::xlen-1:0] wdata,
  output logic [rv_pkg::strb_w-1:0] wstrb,
  output logic wvalid,
  input logic wready,
  input logic bvalid,
  output logic bready
);
  import rv_pkg::*;

  typedef enum logic [2:0] {ls_idle, ls_ar, ls_r, ls_w, ls_b} ls_state_t;

  ls_state_t st;
  logic [xlen-1:0] word_addr;
  logic [xlen-1:0] st_data;
  logic [strb_w-1:0] st_strb;
  logic [xlen-1:0] ld_data;
  logic [7:0] ld_byte;
  logic [15:0] ld_half;

  assign word_addr = {mem.addr[xlen-1:2], 2'b00};

  // big endian lanes with offset 0 in the top byte
  always_comb begin
    case (mem.size)
      sz_byte: begin
        st_data = {24'b0, mem.wdata[7:0]} << {~mem.addr[1:0], 3'b000};
        st_strb = 4'b0001 << ~mem.addr[1:0];
      end
      sz_half: begin
        st_data = {16'b0, mem.wdata[15:0]} << {~mem.addr[1], 4'b0000};
        st_strb = 4'b0011 << {~mem.addr[1], 1'b0};
      end
      default: begin
        st_data = mem.wdata;
        st_strb = '1;
      end
    endcase
  end

  assign ld_byte = 8'(rdata >> {~mem.addr[1:0], 3'b000});
  assign ld_half = 16'(rdata >> {~mem.addr[1], 4'b0000});

  always_comb begin
    if (mem.kind == mk_fetch) ld_data = rdata; // raw instruction
    else if (mem.size == sz_byte) ld_data = {{24{ld_byte[7] & ~mem.is_unsigned}}, ld_byte};
    else if (mem.size == sz_half) ld_data = {{16{ld_half[15] & ~mem.is_unsigned}}, ld_half};
    else ld_data = rdata;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      st <= ls_idle;
      arvalid <= 1'b0;
      rready <= 1'b0;
      awvalid <= 1'b0;
      wvalid <= 1'b0;
      bready <= 1'b0;
      mem.done <= 1'b0;
    end else begin
      mem.done <= 1'b0;
      case (st)
        ls_idle: begin
          if (mem.req && !mem.done) begin // req still high in the done cycle
            if (mem.kind == mk_store) begin
              awvalid <= 1'b1;
              wvalid <= 1'b1;
              st <= ls_w;
            end else begin
              arvalid <= 1'b1;
              st <= ls_ar;
            end
          end
        end
        ls_ar: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready <= 1'b1;
            st <= ls_r;
          end
        end
        ls_r: begin
          if (rvalid) begin
            rready <= 1'b0;
            mem.done <= 1'b1;
            st <= ls_idle;
          end
        end
        ls_w: begin
          if (awready) awvalid <= 1'b0;
          if (wready) wvalid <= 1'b0;
          if ((awready || !awvalid) && (wready || !wvalid)) begin
            bready <= 1'b1;
            st <= ls_b;
          end
        end
        ls_b: begin
          if (bvalid) begin
            bready <= 1'b0;
            mem.done <= 1'b1;
            st <= ls_idle;
          end
        end
        default: st <= ls_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (st == ls_idle && mem.req) begin
      araddr <= word_addr;
      awaddr <= word_addr;
      wdata <= st_data;
      wstrb <= st_strb;
    end
    if (st == ls_r && rvalid) mem.rdata <= ld_data;
  end

  a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
    arvalid && !arready |=> arvalid);
  a_no_write_in_read: assert property (@(posedge clk) disable iff (!rstn)
    (arvalid || rready) |-> !(awvalid || wvalid));

endmodule

`default_nettype wire

/* source/rv_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
  input logic clk,
  input logic rstn,
  dec_if.consumer dec,
  input logic [rv_pkg::xlen-1:0] rs1_data,
  input logic [rv_pkg::xlen-1:0] rs2_data,
  output logic [rv_pkg::xlen-1:0] result
);
  import rv_pkg::*;

  logic [xlen-1:0] a;
  logic [xlen-1:0] b;
  logic [$clog2(xlen)-1:0] shamt;

  assign a = rs1_data;
  assign b = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = b[$clog2(xlen)-1:0];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      result <= '0;
    end else begin
      case (dec.alu_fn)
        alu_add: result <= a + b;
        alu_sub: result <= a - b;
        alu_xor: result <= a ^ b;
        alu_or: result <= a | b;
        alu_and: result <= a & b;
        alu_sll: result <= a << shamt;
        alu_srl: result <= a >> shamt;
        alu_sra: result <= $signed(a) >>> shamt;
        alu_lts: result <= xlen'($signed(a) < $signed(b));
        alu_ltu: result <= xlen'(a < b);
        alu_eq: result <= xlen'(a == b); // branch taken flags
        alu_ne: result <= xlen'(a != b);
        alu_ges: result <= xlen'($signed(a) >= $signed(b));
        alu_geu: result <= xlen'(a >= b);
        default: result <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/rv_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
  input logic clk,
  input logic rstn,
  input logic we,
  input logic [rv_pkg::reg_idx_w-1:0] rd,
  input logic [rv_pkg::xlen-1:0] wdata,
  input logic [rv_pkg::reg_idx_w-1:0] rs1,
  input logic [rv_pkg::reg_idx_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0] rs1_data,
  output logic [rv_pkg::xlen-1:0] rs2_data
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [1:(1 << reg_idx_w)-1]; // x0 not stored

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 1; i < (1 << reg_idx_w); i++) regs[i] <= '0;
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* source/rv_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_decoder (
  input logic clk,
  input logic rstn,
  input logic [rv_pkg::xlen-1:0] instr,
  dec_if.producer dec
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic r_t, i_t, s_t, b_t, u_t, j_t;
  inst_op_t op_n;
  alu_fn_t fn_n;
  logic [xlen-1:0] imm_n;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign r_t = opcode == op_reg;
  assign i_t = opcode == op_imm || opcode == op_load || opcode == op_jalr;
  assign s_t = opcode == op_store;
  assign b_t = opcode == op_branch;
  assign u_t = opcode == op_lui || opcode == op_auipc;
  assign j_t = opcode == op_jal;

  always_comb begin
    op_n = inst_inval;
    fn_n = alu_add;
    case (opcode)
      op_lui: op_n = lui;
      op_auipc: op_n = auipc;
      op_jal: op_n = jal;
      op_jalr: if (funct3 == 3'b000) op_n = jalr;
      op_branch: begin
        case (funct3)
          f3_beq: begin op_n = beq; fn_n = alu_eq; end
          f3_bne: begin op_n = bne; fn_n = alu_ne; end
          f3_blt: begin op_n = blt; fn_n = alu_lts; end
          f3_bge: begin op_n = bge; fn_n = alu_ges; end
          f3_bltu: begin op_n = bltu; fn_n = alu_ltu; end
          f3_bgeu: begin op_n = bgeu; fn_n = alu_geu; end
          default: op_n = inst_inval;
        endcase
      end
      op_load: begin
        case (funct3)
          f3_lb: op_n = lb;
          f3_lh: op_n = lh;
          f3_lw: op_n = lw;
          f3_lbu: op_n = lbu;
          f3_lhu: op_n = lhu;
          default: op_n = inst_inval;
        endcase
      end
      op_store: begin
        case (funct3)
          f3_sb: op_n = sb;
          f3_sh: op_n = sh;
          f3_sw: op_n = sw;
          default: op_n = inst_inval;
        endcase
      end
      op_imm: begin
        case (funct3)
          f3_add: begin op_n = addi; fn_n = alu_add; end
          f3_slt: begin op_n = slti; fn_n = alu_lts; end
          f3_sltu: begin op_n = sltiu; fn_n = alu_ltu; end
          f3_xor: begin op_n = xori; fn_n = alu_xor; end
          f3_or: begin op_n = ori; fn_n = alu_or; end
          f3_and: begin op_n = andi; fn_n = alu_and; end
          f3_sll: if (funct7 == f7_base) begin op_n = slli; fn_n = alu_sll; end
          default: begin // f3_srl
            if (funct7 == f7_base) begin op_n = srli; fn_n = alu_srl; end
            if (funct7 == f7_alt) begin op_n = srai; fn_n = alu_sra; end
          end
        endcase
      end
      op_reg: begin
        case ({funct7, funct3})
          {f7_base, f3_add}: begin op_n = add; fn_n = alu_add; end
          {f7_alt, f3_add}: begin op_n = sub; fn_n = alu_sub; end
          {f7_base, f3_sll}: begin op_n = sll; fn_n = alu_sll; end
          {f7_base, f3_slt}: begin op_n = slt; fn_n = alu_lts; end
          {f7_base, f3_sltu}: begin op_n = sltu; fn_n = alu_ltu; end
          {f7_base, f3_xor}: begin op_n = xor_; fn_n = alu_xor; end
          {f7_base, f3_srl}: begin op_n = srl; fn_n = alu_srl; end
          {f7_alt, f3_srl}: begin op_n = sra; fn_n = alu_sra; end
          {f7_base, f3_or}: begin op_n = or_; fn_n = alu_or; end
          {f7_base, f3_and}: begin op_n = and_; fn_n = alu_and; end
          default: op_n = inst_inval;
        endcase
      end
      default: op_n = inst_inval;
    endcase
  end

  always_comb begin
    if (i_t) imm_n = {{21{instr[31]}}, instr[30:20]};
    else if (s_t) imm_n = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    else if (b_t) imm_n = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    else if (u_t) imm_n = {instr[31:12], 12'd0};
    else if (j_t) imm_n = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    else imm_n = '0;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      dec.op <= inst_inval;
      dec.alu_fn <= alu_add;
      dec.use_imm <= 1'b0;
    end else begin
      dec.op <= op_n;
      dec.alu_fn <= fn_n;
      dec.use_imm <= !(r_t || b_t);
    end
  end

  always_ff @(posedge clk) begin
    dec.rd <= (r_t || i_t || u_t || j_t) ? instr[11:7] : '0;
    dec.rs1 <= (r_t || i_t || s_t || b_t) ? instr[19:15] : '0;
    dec.rs2 <= (r_t || s_t || b_t) ? instr[24:20] : '0;
    dec.imm <= imm_n;
  end

  a_instr_known: assert property (@(posedge clk) disable iff (!rstn) !$isunknown(instr));

endmodule

`default_nettype wire

/* source/rv_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface dec_if;
  import rv_pkg::*;

  inst_op_t op;
  alu_fn_t alu_fn;
  logic use_imm; // second alu operand is imm
  logic [reg_idx_w-1:0] rd;
  logic [reg_idx_w-1:0] rs1;
  logic [reg_idx_w-1:0] rs2;
  logic [xlen-1:0] imm;

  modport producer (output op, alu_fn, use_imm, rd, rs1, rs2, imm);
  modport consumer (input op, alu_fn, use_imm, rd, rs1, rs2, imm);
endinterface

interface mem_if;
  import rv_pkg::*;

  logic req;
  mem_kind_t kind;
  logic [xlen-1:0] addr; // byte address
  mem_size_t size;
  logic is_unsigned;
  logic [xlen-1:0] wdata;
  logic done; // one cycle pulse
  logic [xlen-1:0] rdata;

  modport master (output req, kind, addr, size, is_unsigned, wdata, input done, rdata);
  modport slave (input req, kind, addr, size, is_unsigned, wdata, output done, rdata);
endinterface

`default_nettype wire

/* source/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_idx_w = 5;
  localparam int strb_w = 4;
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;
  localparam logic [2:0] f3_lb   = 3'b000;
  localparam logic [2:0] f3_lh   = 3'b001;
  localparam logic [2:0] f3_lw   = 3'b010;
  localparam logic [2:0] f3_lbu  = 3'b100;
  localparam logic [2:0] f3_lhu  = 3'b101;
  localparam logic [2:0] f3_sb   = 3'b000;
  localparam logic [2:0] f3_sh   = 3'b001;
  localparam logic [2:0] f3_sw   = 3'b010;
  localparam logic [2:0] f3_add  = 3'b000; // add, sub, addi
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101; // srl and sra
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  typedef enum logic [5:0] {
    lui, auipc, jal, jalr, beq, bne, blt, bge, bltu, bgeu,
    lb, lh, lw, lbu, lhu, sb, sh, sw,
    addi, slti, sltiu, xori, ori, andi, slli, srli, srai,
    add, sub, sll, slt, sltu, xor_, srl, sra, or_, and_,
    inst_inval
  } inst_op_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_xor, alu_or, alu_and, alu_sll, alu_srl, alu_sra,
    alu_lts, alu_ltu, alu_eq, alu_ne, alu_ges, alu_geu
  } alu_fn_t;

  typedef enum logic [1:0] {sz_byte, sz_half, sz_word} mem_size_t;

  typedef enum logic [1:0] {mk_fetch, mk_load, mk_store} mem_kind_t;

  typedef enum logic [2:0] {
    st_fetch, st_decode, st_exec, st_mem, st_write, st_halt
  } core_state_t;

endpackage

`default_nettype wire
